//--- design/frame_seq.sv
`timescale 1ns/10ps
`default_nettype none

module frame_seq import pkt_framer_pkg::*; (
  input  logic      sclk,
  input  logic      rst_n_f,
  // block control
  input  logic      start_blk,   // level whose rising edge opens a block
  input  near_t     quant_near,  // stable while the block is open
  // buffer head
  input  logic      buf_valid,
  input  word_t     buf_word,
  input  logic      buf_eob,
  input  byte_cnt_t buf_cnt,
  output logic      buf_pop,     // one cycle per consumed entry
  // downstream valid/ready
  output logic      out_valid,
  output word_t     out_data,
  input  logic      out_ready,
  // block status
  output logic      block_done,  // high while trailer is offered
  output logic      done_ack     // pulse after trailer transfer
);

  seq_state_t state;
  seq_state_t state_nxt;

  // start edge detection
  logic start_q;     // sampled start_blk
  logic start_q2;    // delayed copy
  logic start_rise;  // one cycle per rising edge
  logic go;          // open a block now

  logic      xfer;     // word accepted downstream
  word_t     hdr_word;
  word_t     trl_word;
  byte_cnt_t trl_cnt;  // count of the block being closed

  // sample start_blk and keep a delayed copy
  always_ff @(posedge sclk or negedge rst_n_f) begin : start_sync
    if (!rst_n_f) begin
      start_q  <= 1'b0;
      start_q2 <= 1'b0;
    end else begin
      start_q  <= start_blk;
      start_q2 <= start_q;
    end
  end

  assign start_rise = start_q & ~start_q2;

  // next block only opens from IDLE
  assign go = (state == IDLE) & start_rise;

  // handshake
  assign xfer = out_valid & out_ready;

  // header and trailer words built from the marks
  assign hdr_word = {HDR_MARK, 30'd0, quant_near};
  assign trl_word = {8'd0, trl_cnt, TRL_MARK};

  // next state
  always_comb begin : fsm_nxt
    state_nxt = state;
    case (state)
      IDLE: begin
        if (go) begin
          state_nxt = HDR;
        end
      end
      HDR: begin
        if (xfer) begin
          state_nxt = DATA;  // header gone
        end
      end
      DATA: begin
        if (xfer && buf_eob) begin
          state_nxt = TRAIL;  // last data word gone
        end
      end
      TRAIL: begin
        if (xfer) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge sclk or negedge rst_n_f) begin : fsm_reg
    if (!rst_n_f) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // output mux held stable by state and buffer head
  always_comb begin : out_mux
    out_valid = 1'b0;
    out_data  = buf_word;  // don't care when not valid
    case (state)
      HDR: begin
        out_valid = 1'b1;
        out_data  = hdr_word;
      end
      DATA: begin
        out_valid = buf_valid;  // head waits until accepted
        out_data  = buf_word;
      end
      TRAIL: begin
        out_valid = 1'b1;
        out_data  = trl_word;
      end
      default: begin
        out_valid = 1'b0;
      end
    endcase
  end

  // consume head only on an accepted data word
  assign buf_pop = (state == DATA) & buf_valid & out_ready;

  assign block_done = (state == TRAIL);

  // trailer count taken from the eob entry as it leaves
  always_ff @(posedge sclk) begin : trl_latch
    if (buf_pop && buf_eob) begin
      trl_cnt <= buf_cnt;
    end
  end

  // done acknowledge one cycle after the trailer transfer
  always_ff @(posedge sclk or negedge rst_n_f) begin : ack_reg
    if (!rst_n_f) begin
      done_ack <= 1'b0;
    end else begin
      done_ack <= block_done & out_ready;  // single cycle since state leaves TRAIL
    end
  end

endmodule

`default_nettype wire

//--- design/pkt_framer.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_framer import pkt_framer_pkg::*; (
  input  logic      sclk,
  input  logic      rst_n_f,
  // encoder write side
  input  logic      w_en,
  input  word_t     w_data,
  input  logic      eob,
  input  byte_cnt_t byte_cnt,
  output logic      wfifo_ready,
  // block control
  input  logic      start_blk,
  input  near_t     quant_near,
  // framed stream out
  output logic      out_valid,
  output word_t     out_data,
  input  logic      out_ready,
  output logic      block_done,
  output logic      done_ack
);

  // buffer head to sequencer
  logic      buf_valid;
  word_t     buf_word;
  logic      buf_eob;
  byte_cnt_t buf_cnt;
  logic      buf_pop;    // back from sequencer

  // capture and ring buffer
  stream_buffer i_buf (
    .sclk        (sclk),
    .rst_n_f     (rst_n_f),
    .w_en        (w_en),
    .w_data      (w_data),
    .eob         (eob),
    .byte_cnt    (byte_cnt),
    .wfifo_ready (wfifo_ready),
    .buf_valid   (buf_valid),
    .buf_word    (buf_word),
    .buf_eob     (buf_eob),
    .buf_cnt     (buf_cnt),
    .buf_pop     (buf_pop)
  );

  // header / data / trailer sequencing
  frame_seq i_seq (
    .sclk        (sclk),
    .rst_n_f     (rst_n_f),
    .start_blk   (start_blk),
    .quant_near  (quant_near),
    .buf_valid   (buf_valid),
    .buf_word    (buf_word),
    .buf_eob     (buf_eob),
    .buf_cnt     (buf_cnt),
    .buf_pop     (buf_pop),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready),
    .block_done  (block_done),
    .done_ack    (done_ack)
  );

endmodule

`default_nettype wire

//--- design/pkt_framer_pkg.sv
`default_nettype none

package pkt_framer_pkg;

  // stream widths
  typedef logic [63:0] word_t;      // one stream word in or out
  typedef logic [23:0] byte_cnt_t;  // compressed bytes per block, as written in the trailer
  typedef logic [5:0]  near_t;      // quantization near for the header

  // header is mark | 30 zeros | near
  localparam logic [27:0] HDR_MARK = 28'hFFF_FFFF;
  // trailer is 8 zeros | byte count | mark
  localparam logic [31:0] TRL_MARK = 32'hFFEE_DDC9;

  // write buffer sizing
  localparam int BUF_DEPTH = 16;                 // power of two, pointers wrap
  localparam int BUF_SLACK = 3;                  // free entries kept for in-flight writes
  localparam int BUF_AW    = $clog2(BUF_DEPTH);  // pointer width

  typedef logic [BUF_AW-1:0] buf_ptr_t;   // read / write pointer
  typedef logic [BUF_AW:0]   buf_fill_t;  // 0..BUF_DEPTH plus the capture stage

  // highest occupancy at which new writes are still allowed
  localparam buf_fill_t FILL_LIMIT = buf_fill_t'(BUF_DEPTH - BUF_SLACK);

  // block sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // waiting for start_blk edge
    HDR   = 2'd1,  // header word offered
    DATA  = 2'd2,  // forwarding buffer head
    TRAIL = 2'd3   // trailer word offered
  } seq_state_t;

endpackage

`default_nettype wire

//--- design/stream_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module stream_buffer import pkt_framer_pkg::*; (
  input  logic      sclk,
  input  logic      rst_n_f,
  // producer side
  input  logic      w_en,         // write strobe, only while wfifo_ready
  input  word_t     w_data,       // compressed word
  input  logic      eob,          // last word of the block
  input  byte_cnt_t byte_cnt,     // valid with eob
  output logic      wfifo_ready,  // registered write-allowed level
  // head entry towards the sequencer
  output logic      buf_valid,    // head entry present
  output word_t     buf_word,
  output logic      buf_eob,
  output byte_cnt_t buf_cnt,
  input  logic      buf_pop       // consume head entry
);

  // capture stage
  logic      cap_vld;  // capture holds a word to push
  word_t     cap_word;
  logic      cap_eob;
  byte_cnt_t cap_cnt;

  // storage, one entry = word + eob + count
  word_t     mem_word [BUF_DEPTH];
  logic      mem_eob  [BUF_DEPTH];
  byte_cnt_t mem_cnt  [BUF_DEPTH];

  buf_ptr_t  wr_ptr;
  buf_ptr_t  rd_ptr;
  buf_fill_t fill;     // entries in the ring
  buf_fill_t occ;      // ring plus capture stage

  logic      buf_wr;   // capture moves into the ring
  logic      buf_rd;   // head leaves the ring

  // capture register, one cycle in front of the ring
  always_ff @(posedge sclk or negedge rst_n_f) begin : cap_ctrl
    if (!rst_n_f) begin
      cap_vld <= 1'b0;
    end else begin
      cap_vld <= w_en;  // pushes next cycle
    end
  end

  always_ff @(posedge sclk) begin : cap_data
    if (w_en) begin
      cap_word <= w_data;
      cap_eob  <= eob;
      cap_cnt  <= byte_cnt;  // kept for every word, used on eob only
    end
  end

  assign buf_wr = cap_vld;                 // room is guaranteed by wfifo_ready
  assign buf_rd = buf_pop & buf_valid;     // ignore pop on empty

  // ring storage
  always_ff @(posedge sclk) begin : ring_write
    if (buf_wr) begin
      mem_word[wr_ptr] <= cap_word;
      mem_eob[wr_ptr]  <= cap_eob;
      mem_cnt[wr_ptr]  <= cap_cnt;
    end
  end

  // pointers and fill level
  always_ff @(posedge sclk or negedge rst_n_f) begin : ring_ptrs
    if (!rst_n_f) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (buf_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at BUF_DEPTH
      end
      if (buf_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({buf_wr, buf_rd})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;  // both or neither
      endcase
    end
  end

  // first word fall through, head shown straight from the ring
  assign buf_valid = (fill != '0);
  assign buf_word  = mem_word[rd_ptr];
  assign buf_eob   = mem_eob[rd_ptr];
  assign buf_cnt   = mem_cnt[rd_ptr];

  // occupancy counts the word still sitting in capture
  assign occ = fill + buf_fill_t'(cap_vld);

  // write-allowed level, one cycle behind occupancy
  // a write already granted plus the capture stage fit in the slack
  always_ff @(posedge sclk or negedge rst_n_f) begin : ready_reg
    if (!rst_n_f) begin
      wfifo_ready <= 1'b0;  // rises on the first edge after reset
    end else begin
      wfifo_ready <= (occ <= FILL_LIMIT);
    end
  end

endmodule

`default_nettype wire

//--- dv/pkt_framer_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_framer_asserts import pkt_framer_pkg::*; (
  input logic  sclk,
  input logic  rst_n_f,
  input logic  w_en,
  input logic  wfifo_ready,
  input logic  out_valid,
  input word_t out_data,
  input logic  out_ready,
  input logic  block_done,
  input logic  done_ack
);

  // offered word holds until taken
  a_hold: assert property (@(posedge sclk) disable iff (!rst_n_f)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("out_valid or out_data changed while out_ready was low");

  a_done_valid: assert property (@(posedge sclk) disable iff (!rst_n_f)
    block_done |-> out_valid)
    else $error("block_done high without out_valid");

  // single-cycle ack
  a_ack_pulse: assert property (@(posedge sclk) disable iff (!rst_n_f)
    done_ack |=> !done_ack)
    else $error("done_ack longer than one cycle");

  // ack only after a trailer handshake
  a_ack_cause: assert property (@(posedge sclk) disable iff (!rst_n_f)
    done_ack |-> $past(block_done && out_valid && out_ready))
    else $error("done_ack without a trailer transfer before it");

  a_no_overrun: assert property (@(posedge sclk) disable iff (!rst_n_f)
    w_en |-> wfifo_ready)
    else $error("write while wfifo_ready low");

endmodule

bind pkt_framer pkt_framer_asserts i_asserts (
  .sclk        (sclk),
  .rst_n_f     (rst_n_f),
  .w_en        (w_en),
  .wfifo_ready (wfifo_ready),
  .out_valid   (out_valid),
  .out_data    (out_data),
  .out_ready   (out_ready),
  .block_done  (block_done),
  .done_ack    (done_ack)
);

`default_nettype wire

//--- dv/tb_pkt_framer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pkt_framer import pkt_framer_pkg::*; ();

  localparam int N_BLOCKS    = 40;    // blocks per run
  localparam int BLK_TIMEOUT = 2000;  // cycles allowed per block
  localparam int DRV_DLY     = 2;     // ns after the rising edge

  logic      sclk;
  logic      rst_n_f;
  logic      w_en;
  word_t     w_data;
  logic      eob;
  byte_cnt_t byte_cnt;
  logic      wfifo_ready;
  logic      start_blk;
  near_t     quant_near;
  logic      out_valid;
  word_t     out_data;
  logic      out_ready;
  logic      block_done;
  logic      done_ack;

  integer seed;
  int     err_cnt;
  int     tmo_cnt;
  int     ack_cnt;        // done_ack pulses seen
  int     stall_left;     // remaining long-stall cycles
  logic   ack_due;        // trailer went out last cycle
  bit     running;        // past the reset checks
  bit     ready_low_seen;

  // producer side, words still to be written
  word_t     wr_word_q [$];
  logic      wr_eob_q  [$];
  byte_cnt_t wr_cnt_q  [$];
  // expected output stream
  word_t     exp_word_q [$];
  logic      exp_trl_q  [$];  // entry is a trailer
  byte_cnt_t exp_cnt_q  [$];  // one count per block
  near_t     blk_near [N_BLOCKS];

  pkt_framer i_dut (
    .sclk        (sclk),
    .rst_n_f     (rst_n_f),
    .w_en        (w_en),
    .w_data      (w_data),
    .eob         (eob),
    .byte_cnt    (byte_cnt),
    .wfifo_ready (wfifo_ready),
    .start_blk   (start_blk),
    .quant_near  (quant_near),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready),
    .block_done  (block_done),
    .done_ack    (done_ack)
  );

  initial sclk = 1'b0;
  always #50 sclk = ~sclk;  // 100 ns period

  // header is all-ones mark, zeros, near in the low bits
  function automatic word_t make_header(input near_t near);
    return {HDR_MARK, 30'd0, near};
  endfunction

  // trailer is zero byte, count, marker
  function automatic word_t make_trailer(input byte_cnt_t cnt);
    return {8'd0, cnt, TRL_MARK};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("error %s expected %h actual %h", name, want, got);
      err_cnt++;
    end
  endtask

  task automatic check_cnt(input string name, input byte_cnt_t got, input byte_cnt_t want);
    if (got !== want) begin
      $display("error %s expected %h actual %h", name, want, got);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("error %s expected %h actual %h", name, want, got);
      err_cnt++;
    end
  endtask

  // random blocks and the stream they should produce
  task automatic gen_blocks();
    int        len;
    byte_cnt_t cnt;
    word_t     w;
    logic      last;
    for (int b = 0; b < N_BLOCKS; b++) begin
      len         = 1 + ($unsigned($random(seed)) % 12);
      blk_near[b] = near_t'($random(seed));
      cnt         = byte_cnt_t'($random(seed));
      exp_word_q.push_back(make_header(blk_near[b]));
      exp_trl_q.push_back(1'b0);
      for (int i = 0; i < len; i++) begin
        w    = {$random(seed), $random(seed)};
        last = (i == len - 1);
        wr_word_q.push_back(w);
        wr_eob_q.push_back(last);
        // junk count on non-eob words, must be ignored
        wr_cnt_q.push_back(last ? cnt : byte_cnt_t'($random(seed)));
        exp_word_q.push_back(w);
        exp_trl_q.push_back(1'b0);
      end
      exp_word_q.push_back(make_trailer(cnt));
      exp_trl_q.push_back(1'b1);
      exp_cnt_q.push_back(cnt);
    end
  endtask

  task automatic next_cycle();
    @(posedge sclk);
    #DRV_DLY;
  endtask

  // ~40% low, plus occasional long stalls
  task automatic drive_ready();
    if (stall_left > 0) begin
      out_ready = 1'b0;
      stall_left--;
    end else if ($unsigned($random(seed)) % 48 == 0) begin
      stall_left = 20 + ($unsigned($random(seed)) % 21);
      out_ready  = 1'b0;
    end else begin
      out_ready = ($unsigned($random(seed)) % 10) >= 4;
    end
  endtask

  // one word per cycle at most, only while ready, some idle cycles
  task automatic drive_write();
    if (wr_word_q.size() > 0 && wfifo_ready && ($unsigned($random(seed)) % 4 != 0)) begin
      w_en     = 1'b1;
      w_data   = wr_word_q.pop_front();
      eob      = wr_eob_q.pop_front();
      byte_cnt = wr_cnt_q.pop_front();
    end else begin
      w_en = 1'b0;
    end
  endtask

  // outputs sampled mid cycle, away from both edges
  always @(negedge sclk) begin : monitor
    word_t     w;
    logic      trl;
    byte_cnt_t c;
    if (rst_n_f) begin
      if (running && !wfifo_ready) ready_low_seen = 1'b1;
      check_flag("done_ack", done_ack, ack_due);
      if (done_ack) ack_cnt++;
      ack_due = 1'b0;
      if (out_valid && out_ready) begin
        if (exp_word_q.size() == 0) begin
          $display("output word %h transferred while no word was expected", out_data);
          err_cnt++;
        end else begin
          w   = exp_word_q.pop_front();
          trl = exp_trl_q.pop_front();
          check_word("out_data", out_data, w);
          check_flag("block_done", block_done, trl);
          if (trl) begin
            c = exp_cnt_q.pop_front();
            check_cnt("trailer byte_cnt", byte_cnt_t'(out_data[55:32]), c);
            ack_due = 1'b1;  // pulse expected next cycle
          end
        end
      end
    end
  end

  initial begin : main
    int cur_blk;
    bit blk_open;
    int start_wait;
    int blk_cycles;
    seed = 73;
    err_cnt = 0;
    tmo_cnt = 0;
    ack_cnt = 0;
    stall_left = 0;
    ack_due = 1'b0;
    running = 1'b0;
    ready_low_seen = 1'b0;
    rst_n_f = 1'b0;
    w_en = 1'b0;
    w_data = '0;
    eob = 1'b0;
    byte_cnt = '0;
    start_blk = 1'b0;
    quant_near = '0;
    out_ready = 1'b0;
    gen_blocks();
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      check_flag("wfifo_ready", wfifo_ready, 1'b0);
      check_flag("out_valid", out_valid, 1'b0);
      check_flag("block_done", block_done, 1'b0);
      check_flag("done_ack", done_ack, 1'b0);
    end
    rst_n_f = 1'b1;
    check_flag("wfifo_ready", wfifo_ready, 1'b0);  // not yet, one edge to go
    next_cycle();
    check_flag("wfifo_ready", wfifo_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("block_done", block_done, 1'b0);
    check_flag("done_ack", done_ack, 1'b0);
    running = 1'b1;
    cur_blk = 0;
    blk_open = 1'b0;
    start_wait = $unsigned($random(seed)) % 6;  // data may lead the header
    blk_cycles = 0;
    while (cur_blk < N_BLOCKS) begin
      next_cycle();
      drive_ready();
      drive_write();
      if (blk_open) begin
        if (done_ack) begin
          start_blk  = 1'b0;  // low at least one edge before next block
          blk_open   = 1'b0;
          cur_blk++;
          start_wait = $unsigned($random(seed)) % 6;
          blk_cycles = 0;
        end
      end else if (start_wait > 0) begin
        start_wait--;
      end else begin
        quant_near = blk_near[cur_blk];  // held until done_ack
        start_blk  = 1'b1;
        blk_open   = 1'b1;
      end
      blk_cycles++;
      if (blk_cycles > BLK_TIMEOUT) begin
        $display("timeout: block %0d was not acknowledged within %0d cycles",
                 cur_blk, BLK_TIMEOUT);
        tmo_cnt++;
        break;
      end
    end
    w_en = 1'b0;
    out_ready = 1'b0;
    repeat (2) next_cycle();  // let the last done_ack be sampled
    if (tmo_cnt == 0) begin
      if (exp_word_q.size() != 0 || wr_word_q.size() != 0) begin
        $display("stream ended with %0d expected words never seen", exp_word_q.size());
        err_cnt++;
      end
      if (ack_cnt != N_BLOCKS) begin
        $display("saw %0d done_ack pulses for %0d blocks", ack_cnt, N_BLOCKS);
        err_cnt++;
      end
      if (!ready_low_seen) begin
        $display("wfifo_ready never dropped during the stalls");
        err_cnt++;
      end
    end
    $display("blocks %0d, check errors %0d, timeouts %0d", cur_blk, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/pkt_framer_pkg.sv
design/stream_buffer.sv
design/frame_seq.sv
design/pkt_framer.sv
dv/pkt_framer_asserts.sv
dv/tb_pkt_framer.sv

//--- run.sh
#!/usr/bin/env bash
# builds the framer testbench with Verilator and runs it
# status is nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pkt_framer -Mdir obj_dir -f project.f \
  && ./obj_dir/Vtb_pkt_framer | tee /dev/stderr | grep -x "Test passed" > /dev/null \
  || { echo "simulation did not pass" >&2; exit 1; }

exit 0
